//--- Bender.yml
package:
  name: instr_decoder

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/id_pkg.sv
      - source/ctrl_decode.sv
      - source/cond_check.sv
      - source/branch_target.sv
      - source/reg_data_gen.sv
      - source/instr_decoder.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/instr_decoder_sva.sv
      - testbench/instr_decoder_tb.sv

//--- instr_decoder.f
+incdir+source
source/id_pkg.sv
source/ctrl_decode.sv
source/cond_check.sv
source/branch_target.sv
source/reg_data_gen.sv
source/instr_decoder.sv
testbench/instr_decoder_sva.sv
testbench/instr_decoder_tb.sv

//--- source/branch_target.sv
// offset is a signed word count; target is zero for every non-branch opcode
`timescale 1ns/1ns
`include "id_macros.svh"

module branch_target (
    input  id_pkg::instr_word_t   instruction,
    input  logic [`ID_WORD_W-1:0] re_pc_val,
    input  logic [`ID_WORD_W-1:0] reg1_val,       // branch pointer for br
    output logic [`ID_WORD_W-1:0] wr_pc_val
);

    logic [`ID_WORD_W-1:0] offset_x4;   // sign extended, byte aligned

    // replicate sign bit, two zero lsbs give the times four
    assign offset_x4 = {{(`ID_WORD_W-`ID_IMM_W-2){instruction.br.offset[`ID_IMM_W-1]}},
                        instruction.br.offset, 2'b00};

    always_comb begin
        case (instruction.br.op)
            `ID_OP_B, `ID_OP_BCOND: begin
                wr_pc_val = re_pc_val + offset_x4;  // pc relative
            end
            `ID_OP_BR: begin
                wr_pc_val = reg1_val + offset_x4;   // register relative
            end
            default: begin
                wr_pc_val = '0;
            end
        endcase
    end

endmodule

//--- source/cond_check.sv
// evaluates only codes 0 to 11; codes 12 to 15 never pass, valid for any opcode
`timescale 1ns/1ns
`include "id_macros.svh"

module cond_check (
    input  id_pkg::instr_word_t   instruction,
    input  logic [`ID_WORD_W-1:0] re_cpsr_val,    // only n z c v used
    output logic                  cond_met
);

    logic n, z, c, v;

    assign n = re_cpsr_val[`ID_FLAG_N];
    assign z = re_cpsr_val[`ID_FLAG_Z];
    assign c = re_cpsr_val[`ID_FLAG_C];
    assign v = re_cpsr_val[`ID_FLAG_V];

    always_comb begin
        case (instruction.br.cond)
            `ID_COND_EQ: cond_met = z;
            `ID_COND_NE: cond_met = ~z;
            `ID_COND_CS: cond_met = c;
            `ID_COND_CC: cond_met = ~c;
            `ID_COND_MI: cond_met = n;
            `ID_COND_PL: cond_met = ~n;
            `ID_COND_VS: cond_met = v;
            `ID_COND_VC: cond_met = ~v;
            `ID_COND_HI: cond_met = ~z & c;         // unsigned higher
            `ID_COND_LS: cond_met = ~(~z & c);      // inverse of hi
            `ID_COND_GE: cond_met = (n == z);       // compares n with z, as the core does
            `ID_COND_LT: cond_met = (n != z);
            default:     cond_met = 1'b0;           // reserved codes
        endcase
    end

endmodule

//--- source/ctrl_decode.sv
// enables and strobes forced low during reset and after halt; unused addresses read as zero
`timescale 1ns/1ns
`include "id_macros.svh"

module ctrl_decode (
    input  logic                       clk,
    input  logic                       reset,
    input  id_pkg::instr_word_t        instruction,
    input  logic                       cond_met,       // from cond_check
    output logic [`ID_REG_ADDR_W-1:0]  read_addr1,
    output logic [`ID_REG_ADDR_W-1:0]  read_addr2,
    output logic [`ID_REG_ADDR_W-1:0]  write_addr,
    output logic                       write_data_sel,
    output logic                       write_enable,
    output logic                       wr_cpsr,
    output logic [`ID_ALU_OP_W-1:0]    opcode,
    output logic                       ir_op,
    output logic                       data_read,
    output logic                       data_write,
    output logic                       wr_pc,
    output logic                       pc_mux,
    output logic                       halt_flag
);

    logic we_raw;       // register write before gating
    logic cpsr_raw;     // status write before gating
    logic rd_raw;       // memory read before gating
    logic wr_raw;       // memory write before gating
    logic pc_raw;       // pc load before gating
    logic hold;         // blocks every enable

    // sticky halt, only reset brings the core back
    always_ff @(posedge clk) begin
        if (reset) begin
            halt_flag <= 1'b0;
        end else if (instruction.data.op == `ID_OP_HALT) begin
            halt_flag <= 1'b1;
        end
    end

    assign hold = reset | halt_flag;

    always_comb begin
        read_addr1     = '0;
        read_addr2     = '0;
        write_addr     = '0;
        write_data_sel = 1'b0;                          // default: value from decoder
        opcode         = '0;
        ir_op          = 1'b0;
        we_raw         = 1'b0;
        cpsr_raw       = 1'b0;
        rd_raw         = 1'b0;
        wr_raw         = 1'b0;
        pc_raw         = 1'b0;
        case (instruction.data.op)
            `ID_OP_LOAD: begin
                read_addr1 = instruction.data.rs1;      // pointer reg
                write_addr = instruction.data.rd;
                we_raw     = 1'b1;
                rd_raw     = 1'b1;                      // mem data goes to reg file
            end
            `ID_OP_STOR: begin
                read_addr1 = instruction.data.rd;       // source reg -> data_out
                read_addr2 = instruction.data.rs1;      // pointer reg -> data_addr
                wr_raw     = 1'b1;
            end
            `ID_OP_MOV, `ID_OP_MOVT: begin
                read_addr1 = instruction.data.rd;       // keeps the other half of rd
                write_addr = instruction.data.rd;
                we_raw     = 1'b1;
            end
            `ID_OP_LSL, `ID_OP_LSR: begin
                read_addr1 = instruction.data.rs1;      // shift source
                write_addr = instruction.data.rd;
                we_raw     = 1'b1;
            end
            `ID_OP_CLR, `ID_OP_SET: begin
                write_addr = instruction.data.rd;       // constant, no read needed
                we_raw     = 1'b1;
            end
            `ID_OP_ADD, `ID_OP_SUB, `ID_OP_AND, `ID_OP_OR, `ID_OP_XOR,
            `ID_OP_ADDS, `ID_OP_SUBS, `ID_OP_ANDS, `ID_OP_ORS, `ID_OP_XORS: begin
                opcode         = instruction.data.op[`ID_ALU_OP_W-1:0];
                read_addr1     = instruction.data.rs1;
                write_addr     = instruction.data.rd;
                write_data_sel = 1'b1;                  // alu result
                we_raw         = 1'b1;
                cpsr_raw       = instruction.data.op[3]; // s bit, instr bit 28
            end
            `ID_OP_ADD2, `ID_OP_SUB2, `ID_OP_AND2, `ID_OP_OR2, `ID_OP_XOR2,
            `ID_OP_ADDS2, `ID_OP_SUBS2, `ID_OP_ANDS2, `ID_OP_ORS2, `ID_OP_XORS2: begin
                opcode         = instruction.data.op[`ID_ALU_OP_W-1:0];
                read_addr1     = instruction.data.rs1;
                read_addr2     = instruction.data.rs2;
                write_addr     = instruction.data.rd;
                ir_op          = 1'b1;                  // alu takes reg2 path
                write_data_sel = 1'b1;
                we_raw         = 1'b1;
                cpsr_raw       = instruction.data.op[3];
            end
            `ID_OP_NOT: begin
                opcode         = instruction.data.op[`ID_ALU_OP_W-1:0];
                read_addr1     = instruction.data.rs1;  // single operand
                write_addr     = instruction.data.rd;
                write_data_sel = 1'b1;
                we_raw         = 1'b1;
            end
            `ID_OP_B: begin
                pc_raw = 1'b1;
            end
            `ID_OP_BCOND: begin
                pc_raw = cond_met;
            end
            `ID_OP_BR: begin
                read_addr1 = instruction.data.rd;       // branch pointer in 24:22
                pc_raw     = 1'b1;
            end
            default: begin
                // nop, halt and unknown codes leave everything low
            end
        endcase
    end

    assign write_enable = we_raw & ~hold;
    assign wr_cpsr      = cpsr_raw & ~hold;
    assign data_read    = rd_raw & ~hold;
    assign data_write   = wr_raw & ~hold;
    assign wr_pc        = pc_raw & ~hold;
    assign pc_mux       = pc_raw & ~hold;               // decoder owns pc on a load

endmodule

//--- source/id_macros.svh
// fixed 32-bit, 8-register ISA; opcode and condition encodings must match the assembler
`ifndef ID_MACROS_SVH
`define ID_MACROS_SVH

`define ID_WORD_W       32              // data and instruction width
`define ID_REG_ADDR_W   3               // eight registers
`define ID_IMM_W        16              // immediate and branch offset
`define ID_OP_W         7               // top opcode field, bits 31:25
`define ID_ALU_OP_W     3               // alu opcode, bits 27:25
`define ID_COND_W       4               // branch condition, bits 24:21

// memory and move group
`define ID_OP_LOAD      7'b1000000
`define ID_OP_STOR      7'b1000001
`define ID_OP_MOV       7'b0000000
`define ID_OP_MOVT      7'b0000001
`define ID_OP_CLR       7'b0000010
`define ID_OP_SET       7'b0000011
`define ID_OP_LSL       7'b0000100
`define ID_OP_LSR       7'b0000101

// alu immediate forms, bit 28 selects flag update
`define ID_OP_ADD       7'b0010001
`define ID_OP_SUB       7'b0010010
`define ID_OP_AND       7'b0010011
`define ID_OP_OR        7'b0010100
`define ID_OP_XOR       7'b0010101
`define ID_OP_ADDS      7'b0011001
`define ID_OP_SUBS      7'b0011010
`define ID_OP_ANDS      7'b0011011
`define ID_OP_ORS       7'b0011100
`define ID_OP_XORS      7'b0011101

// alu register forms
`define ID_OP_ADD2      7'b0110001
`define ID_OP_SUB2      7'b0110010
`define ID_OP_AND2      7'b0110011
`define ID_OP_OR2       7'b0110100
`define ID_OP_XOR2      7'b0110101
`define ID_OP_NOT       7'b0110110
`define ID_OP_ADDS2     7'b0111001
`define ID_OP_SUBS2     7'b0111010
`define ID_OP_ANDS2     7'b0111011
`define ID_OP_ORS2      7'b0111100
`define ID_OP_XORS2     7'b0111101

// flow control
`define ID_OP_B         7'b1100000
`define ID_OP_BCOND     7'b1100001
`define ID_OP_BR        7'b1100010
`define ID_OP_NOP       7'b1100100
`define ID_OP_HALT      7'b1101000

`define ID_COND_EQ      4'b0000
`define ID_COND_NE      4'b0001
`define ID_COND_CS      4'b0010
`define ID_COND_CC      4'b0011
`define ID_COND_MI      4'b0100
`define ID_COND_PL      4'b0101
`define ID_COND_VS      4'b0110
`define ID_COND_VC      4'b0111
`define ID_COND_HI      4'b1000
`define ID_COND_LS      4'b1001
`define ID_COND_GE      4'b1010
`define ID_COND_LT      4'b1011

`define ID_FLAG_N       31              // status word bit positions
`define ID_FLAG_Z       30
`define ID_FLAG_C       29
`define ID_FLAG_V       28

`endif

//--- source/id_pkg.sv
// instruction word views only; both layouts share the opcode in bits 31:25
`include "id_macros.svh"

package id_pkg;

    // one word, two decodings: data ops and branches
    typedef union packed {
        struct packed {
            logic [`ID_OP_W-1:0]       op;     // bits 31:25, alu op in 27:25
            logic [`ID_REG_ADDR_W-1:0] rd;     // dest, store source, branch pointer
            logic [`ID_REG_ADDR_W-1:0] rs1;    // op 1, memory pointer, shift source
            logic [`ID_REG_ADDR_W-1:0] rs2;    // op 2 for register forms
            logic [`ID_IMM_W-1:0]      imm;    // immediate
        } data;
        struct packed {
            logic [`ID_OP_W-1:0]       op;     // same field as data.op
            logic [`ID_COND_W-1:0]     cond;   // bits 24:21
            logic [4:0]                unused; // bits 20:16, ignored
            logic [`ID_IMM_W-1:0]      offset; // word offset, signed
        } br;
    } instr_word_t;

endpackage

//--- source/instr_decoder.sv
// single-cycle decoder; only halt_flag is registered, reg values must follow read addresses
`timescale 1ns/1ns
`include "id_macros.svh"

module instr_decoder (
    input  logic                       clk,
    input  logic                       reset,          // sync, active high
    input  id_pkg::instr_word_t        instruction,
    input  logic [`ID_WORD_W-1:0]      reg1_val,       // value at read_addr1
    input  logic [`ID_WORD_W-1:0]      reg2_val,       // value at read_addr2
    input  logic [`ID_WORD_W-1:0]      re_cpsr_val,    // status word
    input  logic [`ID_WORD_W-1:0]      re_pc_val,      // current pc
    output logic                       halt_flag,
    output logic [`ID_REG_ADDR_W-1:0]  read_addr1,
    output logic [`ID_REG_ADDR_W-1:0]  read_addr2,
    output logic [`ID_REG_ADDR_W-1:0]  write_addr,
    output logic [`ID_WORD_W-1:0]      write_data,
    output logic                       write_data_sel, // 1 -> alu result
    output logic                       write_enable,
    output logic                       wr_cpsr,
    output logic [`ID_WORD_W-1:0]      data_addr,
    output logic                       data_read,
    output logic                       data_write,
    output logic [`ID_WORD_W-1:0]      data_out,
    output logic [`ID_ALU_OP_W-1:0]    opcode,
    output logic [`ID_WORD_W-1:0]      operand2,
    output logic                       ir_op,          // 1 -> register operand
    output logic [`ID_WORD_W-1:0]      wr_pc_val,
    output logic                       wr_pc,
    output logic                       pc_mux          // 1 -> decoder drives pc
);

    logic cond_met; // branch condition passes

    ctrl_decode ctrl_decode_i (
        .clk            (clk),
        .reset          (reset),
        .instruction    (instruction),
        .cond_met       (cond_met),
        .read_addr1     (read_addr1),
        .read_addr2     (read_addr2),
        .write_addr     (write_addr),
        .write_data_sel (write_data_sel),
        .write_enable   (write_enable),
        .wr_cpsr        (wr_cpsr),
        .opcode         (opcode),
        .ir_op          (ir_op),
        .data_read      (data_read),
        .data_write     (data_write),
        .wr_pc          (wr_pc),
        .pc_mux         (pc_mux),
        .halt_flag      (halt_flag)
    );

    cond_check cond_check_i (
        .instruction (instruction),
        .re_cpsr_val (re_cpsr_val),
        .cond_met    (cond_met)
    );

    branch_target branch_target_i (
        .instruction (instruction),
        .re_pc_val   (re_pc_val),
        .reg1_val    (reg1_val),
        .wr_pc_val   (wr_pc_val)
    );

    reg_data_gen reg_data_gen_i (
        .instruction (instruction),
        .reg1_val    (reg1_val),
        .reg2_val    (reg2_val),
        .write_data  (write_data),
        .operand2    (operand2),
        .data_addr   (data_addr),
        .data_out    (data_out)
    );

endmodule

//--- source/reg_data_gen.sv
// immediates are zero extended here; reg1_val and reg2_val must match the current read addresses
`timescale 1ns/1ns
`include "id_macros.svh"

module reg_data_gen (
    input  id_pkg::instr_word_t   instruction,
    input  logic [`ID_WORD_W-1:0] reg1_val,
    input  logic [`ID_WORD_W-1:0] reg2_val,
    output logic [`ID_WORD_W-1:0] write_data,     // decoder generated reg value
    output logic [`ID_WORD_W-1:0] operand2,       // alu immediate operand
    output logic [`ID_WORD_W-1:0] data_addr,
    output logic [`ID_WORD_W-1:0] data_out
);

    logic [`ID_IMM_W-1:0]  imm;
    logic [`ID_WORD_W-1:0] imm_zx;      // immediate padded with zeros

    assign imm    = instruction.data.imm;
    assign imm_zx = {{(`ID_WORD_W-`ID_IMM_W){1'b0}}, imm};

    always_comb begin
        write_data = '0;
        operand2   = '0;
        data_addr  = '0;
        data_out   = '0;
        case (instruction.data.op)
            `ID_OP_MOV:  write_data = {reg1_val[`ID_WORD_W-1:`ID_IMM_W], imm}; // low half
            `ID_OP_MOVT: write_data = {imm, reg1_val[`ID_IMM_W-1:0]};          // high half
            `ID_OP_LSL:  write_data = reg1_val << imm;
            `ID_OP_LSR:  write_data = reg1_val >> imm;     // logical, zero fill
            `ID_OP_CLR:  write_data = '0;
            `ID_OP_SET:  write_data = '1;
            `ID_OP_ADD, `ID_OP_SUB, `ID_OP_AND, `ID_OP_OR, `ID_OP_XOR,
            `ID_OP_ADDS, `ID_OP_SUBS, `ID_OP_ANDS, `ID_OP_ORS, `ID_OP_XORS: begin
                operand2 = imm_zx;
            end
            `ID_OP_LOAD: begin
                data_addr = reg1_val + imm_zx;      // pointer + offset
            end
            `ID_OP_STOR: begin
                data_addr = reg2_val + imm_zx;      // pointer comes on port 2
                data_out  = reg1_val;               // source register value
            end
            default: begin
                // branches, register alu forms, nop and halt use none of these
            end
        endcase
    end

endmodule

//--- testbench/instr_decoder_sva.sv
// needs instr_decoder_tb as top for its failure counter; inputs must be stable at falling clk
`timescale 1ns/1ns
`include "id_macros.svh"

module instr_decoder_sva (
    input logic                       clk,
    input logic                       reset,
    input id_pkg::instr_word_t        instruction,
    input logic [`ID_WORD_W-1:0]      reg1_val,
    input logic [`ID_WORD_W-1:0]      reg2_val,
    input logic [`ID_WORD_W-1:0]      re_cpsr_val,
    input logic [`ID_WORD_W-1:0]      re_pc_val,
    input logic                       halt_flag,
    input logic [`ID_REG_ADDR_W-1:0]  read_addr1,
    input logic [`ID_REG_ADDR_W-1:0]  read_addr2,
    input logic [`ID_REG_ADDR_W-1:0]  write_addr,
    input logic [`ID_WORD_W-1:0]      write_data,
    input logic                       write_data_sel,
    input logic                       write_enable,
    input logic                       wr_cpsr,
    input logic [`ID_WORD_W-1:0]      data_addr,
    input logic                       data_read,
    input logic                       data_write,
    input logic [`ID_WORD_W-1:0]      data_out,
    input logic [`ID_ALU_OP_W-1:0]    opcode,
    input logic [`ID_WORD_W-1:0]      operand2,
    input logic                       ir_op,
    input logic [`ID_WORD_W-1:0]      wr_pc_val,
    input logic                       wr_pc,
    input logic                       pc_mux
);

    logic [`ID_OP_W-1:0]   op;
    logic                  exp_halt;    // halt state rebuilt from reset and halt
    logic                  hold;        // reset or halted
    logic                  is_imm;      // alu with immediate operand
    logic                  is_reg;      // alu with two register operands
    logic                  is_alu;      // any alu form, not included
    logic                  is_s;        // flag setting form
    logic [`ID_WORD_W-1:0] imm_zx;
    logic [`ID_WORD_W-1:0] off_sx;      // offset in words, sign extended
    logic                  exp_we;
    logic                  exp_pc;
    logic [`ID_WORD_W-1:0] exp_wd;
    logic [`ID_WORD_W-1:0] exp_addr;
    logic [`ID_WORD_W-1:0] exp_pc_val;

    // n z c v taken from the status word by flag position
    function automatic logic cond_passes(input logic [3:0] cond, input logic [31:0] cpsr);
        logic n;
        logic z;
        logic c;
        logic v;
        n = cpsr[`ID_FLAG_N];
        z = cpsr[`ID_FLAG_Z];
        c = cpsr[`ID_FLAG_C];
        v = cpsr[`ID_FLAG_V];
        case (cond)
            `ID_COND_EQ: return z;
            `ID_COND_NE: return !z;
            `ID_COND_CS: return c;
            `ID_COND_CC: return !c;
            `ID_COND_MI: return n;
            `ID_COND_PL: return !n;
            `ID_COND_VS: return v;
            `ID_COND_VC: return !v;
            `ID_COND_HI: return c && !z;
            `ID_COND_LS: return !c || z;
            `ID_COND_GE: return n == z;     // n against z, not v
            `ID_COND_LT: return n != z;
            default:     return 1'b0;       // 12 to 15 never taken
        endcase
    endfunction

    function automatic void report_mismatch(input string name, input logic [31:0] exp_val,
                                            input logic [31:0] act_val);
        $error("Fail at %0t ns: %s expected %h, got %h", $time, name, exp_val, act_val);
        instr_decoder_tb.fail_count = instr_decoder_tb.fail_count + 1;
    endfunction

    // halt is sticky until a reset edge, reset wins over a new halt
    always_ff @(posedge clk) begin
        if (reset) begin
            exp_halt <= 1'b0;
        end else if (op == `ID_OP_HALT) begin
            exp_halt <= 1'b1;
        end
    end

    assign op     = instruction.data.op;
    assign hold   = reset || exp_halt;
    assign is_imm = op inside {`ID_OP_ADD, `ID_OP_SUB, `ID_OP_AND, `ID_OP_OR, `ID_OP_XOR,
                               `ID_OP_ADDS, `ID_OP_SUBS, `ID_OP_ANDS, `ID_OP_ORS, `ID_OP_XORS};
    assign is_reg = op inside {`ID_OP_ADD2, `ID_OP_SUB2, `ID_OP_AND2, `ID_OP_OR2, `ID_OP_XOR2,
                               `ID_OP_ADDS2, `ID_OP_SUBS2, `ID_OP_ANDS2, `ID_OP_ORS2,
                               `ID_OP_XORS2};
    assign is_alu = is_imm || is_reg || op == `ID_OP_NOT;
    assign is_s   = op inside {`ID_OP_ADDS, `ID_OP_SUBS, `ID_OP_ANDS, `ID_OP_ORS, `ID_OP_XORS,
                               `ID_OP_ADDS2, `ID_OP_SUBS2, `ID_OP_ANDS2, `ID_OP_ORS2,
                               `ID_OP_XORS2};
    assign imm_zx = 32'(instruction.data.imm);
    assign off_sx = {{16{instruction.br.offset[15]}}, instruction.br.offset};

    assign exp_we = !hold && (is_alu || op inside {`ID_OP_LOAD, `ID_OP_MOV, `ID_OP_MOVT,
                                                   `ID_OP_LSL, `ID_OP_LSR, `ID_OP_CLR,
                                                   `ID_OP_SET});
    assign exp_pc = !hold && (op == `ID_OP_B || op == `ID_OP_BR ||
                              (op == `ID_OP_BCOND && cond_passes(instruction.br.cond,
                                                                 re_cpsr_val)));
    assign exp_pc_val = ((op == `ID_OP_BR) ? reg1_val : re_pc_val) + off_sx * 32'd4;
    assign exp_addr = (op == `ID_OP_LOAD) ? reg1_val + imm_zx :
                      (op == `ID_OP_STOR) ? reg2_val + imm_zx : '0;

    always_comb begin
        case (op)
            `ID_OP_MOV:  exp_wd = {reg1_val[31:16], instruction.data.imm};
            `ID_OP_MOVT: exp_wd = {instruction.data.imm, reg1_val[15:0]};
            `ID_OP_LSL:  exp_wd = reg1_val << instruction.data.imm;
            `ID_OP_LSR:  exp_wd = reg1_val >> instruction.data.imm;
            `ID_OP_SET:  exp_wd = 32'hffff_ffff;
            default:     exp_wd = '0;       // clr and every other opcode
        endcase
    end

    a_opcode: assert property (@(negedge clk) opcode == (is_alu ? op[2:0] : 3'd0))
        else report_mismatch("opcode", is_alu ? op[2:0] : 3'd0, opcode);
    a_ir_op: assert property (@(negedge clk) ir_op == is_reg)
        else report_mismatch("ir_op", is_reg, ir_op);
    a_wd_sel: assert property (@(negedge clk) write_data_sel == is_alu)
        else report_mismatch("write_data_sel", is_alu, write_data_sel);
    a_operand2: assert property (@(negedge clk) operand2 == (is_imm ? imm_zx : '0))
        else report_mismatch("operand2", is_imm ? imm_zx : '0, operand2);
    a_raddr1: assert property (@(negedge clk) is_alu |-> read_addr1 == instruction.data.rs1)
        else report_mismatch("read_addr1", instruction.data.rs1, read_addr1);
    a_raddr2: assert property (@(negedge clk) is_reg |-> read_addr2 == instruction.data.rs2)
        else report_mismatch("read_addr2", instruction.data.rs2, read_addr2);
    a_waddr: assert property (@(negedge clk) is_alu |-> write_addr == instruction.data.rd)
        else report_mismatch("write_addr", instruction.data.rd, write_addr);
    a_wdata: assert property (@(negedge clk) write_data == exp_wd)
        else report_mismatch("write_data", exp_wd, write_data);
    a_daddr: assert property (@(negedge clk) data_addr == exp_addr)
        else report_mismatch("data_addr", exp_addr, data_addr);
    a_dout: assert property (@(negedge clk) data_out == ((op == `ID_OP_STOR) ? reg1_val : '0))
        else report_mismatch("data_out", (op == `ID_OP_STOR) ? reg1_val : '0, data_out);
    a_we: assert property (@(negedge clk) write_enable == exp_we)
        else report_mismatch("write_enable", exp_we, write_enable);
    a_cpsr: assert property (@(negedge clk) wr_cpsr == (!hold && is_s))
        else report_mismatch("wr_cpsr", !hold && is_s, wr_cpsr);
    a_dread: assert property (@(negedge clk) data_read == (!hold && op == `ID_OP_LOAD))
        else report_mismatch("data_read", !hold && op == `ID_OP_LOAD, data_read);
    a_dwrite: assert property (@(negedge clk) data_write == (!hold && op == `ID_OP_STOR))
        else report_mismatch("data_write", !hold && op == `ID_OP_STOR, data_write);
    a_wr_pc: assert property (@(negedge clk) wr_pc == exp_pc)
        else report_mismatch("wr_pc", exp_pc, wr_pc);
    a_pc_mux: assert property (@(negedge clk) pc_mux == exp_pc)
        else report_mismatch("pc_mux", exp_pc, pc_mux);
    a_pc_val: assert property (@(negedge clk) wr_pc |-> wr_pc_val == exp_pc_val)
        else report_mismatch("wr_pc_val", exp_pc_val, wr_pc_val);
    a_halt: assert property (@(negedge clk) halt_flag == exp_halt)
        else report_mismatch("halt_flag", exp_halt, halt_flag);

endmodule

//--- testbench/instr_decoder_tb.sv
// inputs change 5 ns after the rising edge; all checks come from the bound assertion module
`timescale 1ns/1ns
`include "id_macros.svh"

module instr_decoder_tb;

    localparam int clk_period   = 40;
    localparam int n_alu        = 42;
    localparam int n_wd         = 36;
    localparam int n_mem        = 24;
    localparam int n_cond       = 4;                // per condition code
    localparam int n_br         = 24;
    localparam int n_halt       = 19;
    localparam int total_cycles = 2 + n_alu + n_wd + n_mem + 16 * n_cond + n_br + n_halt;

    localparam logic [`ID_OP_W-1:0] alu_ops [21] = '{
        `ID_OP_ADD, `ID_OP_SUB, `ID_OP_AND, `ID_OP_OR, `ID_OP_XOR,
        `ID_OP_ADDS, `ID_OP_SUBS, `ID_OP_ANDS, `ID_OP_ORS, `ID_OP_XORS,
        `ID_OP_ADD2, `ID_OP_SUB2, `ID_OP_AND2, `ID_OP_OR2, `ID_OP_XOR2, `ID_OP_NOT,
        `ID_OP_ADDS2, `ID_OP_SUBS2, `ID_OP_ANDS2, `ID_OP_ORS2, `ID_OP_XORS2};
    localparam logic [`ID_OP_W-1:0] wd_ops [6] = '{
        `ID_OP_MOV, `ID_OP_MOVT, `ID_OP_LSL, `ID_OP_LSR, `ID_OP_CLR, `ID_OP_SET};
    localparam logic [`ID_OP_W-1:0] flow_ops [3] = '{`ID_OP_B, `ID_OP_BR, `ID_OP_NOP};
    localparam logic [`ID_OP_W-1:0] mixed_ops [10] = '{
        `ID_OP_LOAD, `ID_OP_STOR, `ID_OP_MOV, `ID_OP_LSL, `ID_OP_ADDS2,
        `ID_OP_NOT, `ID_OP_B, `ID_OP_BR, `ID_OP_BCOND, `ID_OP_SET};

    logic                      clk;
    logic                      reset;
    id_pkg::instr_word_t       instruction;
    logic [`ID_WORD_W-1:0]     reg1_val;
    logic [`ID_WORD_W-1:0]     reg2_val;
    logic [`ID_WORD_W-1:0]     re_cpsr_val;
    logic [`ID_WORD_W-1:0]     re_pc_val;
    logic                      halt_flag;
    logic [`ID_REG_ADDR_W-1:0] read_addr1;
    logic [`ID_REG_ADDR_W-1:0] read_addr2;
    logic [`ID_REG_ADDR_W-1:0] write_addr;
    logic [`ID_WORD_W-1:0]     write_data;
    logic                      write_data_sel;
    logic                      write_enable;
    logic                      wr_cpsr;
    logic [`ID_WORD_W-1:0]     data_addr;
    logic                      data_read;
    logic                      data_write;
    logic [`ID_WORD_W-1:0]     data_out;
    logic [`ID_ALU_OP_W-1:0]   opcode;
    logic [`ID_WORD_W-1:0]     operand2;
    logic                      ir_op;
    logic [`ID_WORD_W-1:0]     wr_pc_val;
    logic                      wr_pc;
    logic                      pc_mux;

    int fail_count   = 0;      // bumped by the assertion module
    int test_start   = 0;      // fail_count when the current test began
    int test_num     = 0;
    int tests_failed = 0;

    instr_decoder instr_decoder_i (.*);

    bind instr_decoder instr_decoder_sva instr_decoder_sva_i (.*);

    always #(clk_period / 2) clk = ~clk;

    // random fields in both views, opcode forced
    function automatic id_pkg::instr_word_t rand_word(input logic [`ID_OP_W-1:0] op);
        id_pkg::instr_word_t w;
        w = $urandom;
        w.data.op = op;
        return w;
    endfunction

    task automatic drive(input id_pkg::instr_word_t w, input logic rst);
        @(posedge clk);
        #5;
        reset       = rst;
        instruction = w;
        reg1_val    = $urandom;     // register file contents are free
        reg2_val    = $urandom;
        re_cpsr_val = $urandom;
        re_pc_val   = $urandom;
    endtask

    task automatic end_test(input string name);
        @(negedge clk);             // last instruction sampled here
        #1;
        test_num++;
        if (fail_count != test_start) tests_failed++;
        $display("test %0d %-12s %0d failures", test_num, name, fail_count - test_start);
        test_start = fail_count;
    endtask

    initial begin
        #((total_cycles + 20) * clk_period);
        $display("timeout: stimulus did not finish within %0d cycles", total_cycles + 20);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        id_pkg::instr_word_t w;
        void'($urandom(32'hbb6624ff));
        clk         = 1'b0;
        reset       = 1'b1;
        instruction = {`ID_OP_NOP, 25'd0};
        reg1_val    = '0;
        reg2_val    = '0;
        re_cpsr_val = '0;
        re_pc_val   = '0;
        @(posedge clk);             // drive() releases reset after the second edge

        repeat (n_alu) drive(rand_word(alu_ops[$urandom_range(20, 0)]), 1'b0);
        end_test("alu");

        repeat (n_wd) begin
            w = rand_word(wd_ops[$urandom_range(5, 0)]);
            if (w.data.op == `ID_OP_LSL || w.data.op == `ID_OP_LSR) begin
                w.data.imm = 16'($urandom_range(31, 0));   // keep shifts inside the word
            end
            drive(w, 1'b0);
        end
        end_test("reg_write");

        repeat (n_mem) drive(rand_word($urandom_range(1, 0) ? `ID_OP_LOAD : `ID_OP_STOR), 1'b0);
        end_test("memory");

        for (int c = 0; c < 16; c++) begin
            repeat (n_cond) begin
                w = rand_word(`ID_OP_BCOND);
                w.br.cond = 4'(c);
                drive(w, 1'b0);
            end
        end
        end_test("bcond");

        repeat (n_br) drive(rand_word(flow_ops[$urandom_range(2, 0)]), 1'b0);
        end_test("branch_nop");

        drive(rand_word(`ID_OP_HALT), 1'b0);
        repeat (10) drive(rand_word(mixed_ops[$urandom_range(9, 0)]), 1'b0);
        drive(rand_word(`ID_OP_HALT), 1'b1);                // reset wins over a new halt
        drive(rand_word(`ID_OP_B), 1'b1);
        repeat (6) drive(rand_word(mixed_ops[$urandom_range(9, 0)]), 1'b0);
        end_test("halt_reset");

        $display("%0d tests run, %0d with failures, %0d failed checks",
                 test_num, tests_failed, fail_count);
        if (fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
